// ==== Bender.yml ====
package:
  name: binconv_array

sources:
  - verilog/binconv_pkg.sv
  - verilog/binconv_ctrl_if.sv
  - verilog/binconv_row.sv
  - verilog/binconv_pe.sv
  - verilog/binconv_window_map.sv
  - verilog/binconv_ctrl.sv
  - verilog/binconv_array.sv
  - target: test
    files:
      - tests/tb_binconv_array.sv

// ==== filelist.f ====
verilog/binconv_pkg.sv
verilog/binconv_ctrl_if.sv
verilog/binconv_row.sv
verilog/binconv_pe.sv
verilog/binconv_window_map.sv
verilog/binconv_ctrl.sv
verilog/binconv_array.sv
tests/tb_binconv_array.sv

// ==== tests/tb_binconv_array.sv ====
/*
 * testbench for the binary convolution array, default 2x2 PE grid
 * weights are random words cut into bit-planes, lsb plane first
 * expected sums come from the 3x3 window rule on the tb's own copy of the buffer
 */
`timescale 1ns/10ps

module tb_binconv_array;
  import binconv_pkg::*;

  localparam int unsigned TIMEOUT_CYC = 4000; // about 3x the length of all tests

  logic                                                clk_i;
  logic                                                rst_ni;
  logic                                                enable_i;
  logic                                                clear_i;
  filter_mode_e                                        filter_mode_i;
  logic [QW_W-1:0]                                     qw_i;
  logic                                                act_valid_i;
  logic [BUF_H-1:0][BUF_W-1:0][TP_IN-1:0][ACT_W-1:0]  act_i;
  logic                                                weight_valid_i;
  logic [NR_ROWS-1:0][TP_IN-1:0]                       weight_i;
  logic [NR_PE-1:0][PRES_W-1:0]                        pres_o;
  logic                                                pres_valid_o;

  logic [ACT_W-1:0]  act_m [BUF_H][BUF_W][TP_IN]; // buffer contents, pixel then channel
  logic [QW_MAX-1:0] w_m [NR_ROWS][TP_IN];        // current weight word per tap/channel
  logic [PRES_W-1:0] exp_acc [NR_PE];             // expected accumulator per PE
  int unsigned       word_len;                    // beats per result
  int unsigned       beats_q;
  logic              exp_pv_q;                    // expected result strobe
  int unsigned       errors;
  int unsigned       cycles;

  binconv_array #(
    .PE_H ( PE_H ),
    .PE_W ( PE_W )
  ) i_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .enable_i       ( enable_i       ),
    .clear_i        ( clear_i        ),
    .filter_mode_i  ( filter_mode_i  ),
    .qw_i           ( qw_i           ),
    .act_valid_i    ( act_valid_i    ),
    .act_i          ( act_i          ),
    .weight_valid_i ( weight_valid_i ),
    .weight_i       ( weight_i       ),
    .pres_o         ( pres_o         ),
    .pres_valid_o   ( pres_valid_o   )
  );

  always #50 clk_i = ~clk_i; // 100 ns period

  //////////////////////////////////////////////////
  // strobe model and timeout
  //////////////////////////////////////////////////
  // a result is due one cycle after the word_len-th beat since the last clear
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beats_q  <= 0;
      exp_pv_q <= 1'b0;
    end else begin
      exp_pv_q <= 1'b0;
      if (clear_i) begin
        beats_q <= 0;                          // clear beats a same-cycle beat
      end else if (enable_i && act_valid_i && weight_valid_i) begin
        if (beats_q + 1 == word_len) begin
          beats_q  <= 0;
          exp_pv_q <= 1'b1;
        end else begin
          beats_q <= beats_q + 1;
        end
      end
    end
  end

  property pulse_matches;
    @(posedge clk_i) disable iff (!rst_ni) pres_valid_o == exp_pv_q;
  endproperty

  pulse_check: assert property (pulse_matches)
    else begin
      errors++;
      $display("error pres_valid_o got %h exp %h", $sampled(pres_valid_o), $sampled(exp_pv_q));
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // dot product of PE p's 3x3 window with w_m, ch < 0 means all channels
  function automatic logic [PRES_W-1:0] window_dot(input int p, input int ch);
    logic [PRES_W-1:0] s;
    int gi;
    int gj;
    s  = '0;
    gi = p / PE_W;
    gj = p % PE_W;
    for (int r = 0; r < NR_ROWS; r++) begin
      for (int c = 0; c < TP_IN; c++) begin
        if (ch < 0 || c == ch) begin
          s = s + act_m[gi + r / 3][gj + r % 3][c] * w_m[r][c];
        end
      end
    end
    return s;
  endfunction

  task automatic randomize_act();
    for (int i = 0; i < BUF_H; i++)
      for (int j = 0; j < BUF_W; j++)
        for (int c = 0; c < TP_IN; c++)
          act_m[i][j][c] = ACT_W'($urandom);
  endtask

  task automatic randomize_weights(input int qw);
    for (int r = 0; r < NR_ROWS; r++)
      for (int c = 0; c < TP_IN; c++)
        w_m[r][c] = QW_MAX'($urandom) & QW_MAX'((1 << qw) - 1); // only qw bits
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  task automatic check_results();
    for (int p = 0; p < NR_PE; p++) begin
      assert (pres_o[p] == exp_acc[p])
        else begin
          errors++;
          $display("error pres_o[%0d] got %h exp %h", p, pres_o[p], exp_acc[p]);
        end
    end
  endtask

  // mode, precision and buffer change only while no beat is pending
  task automatic setup_word(input filter_mode_e mode, input int qw);
    @(posedge clk_i);
    #10;
    filter_mode_i = mode;
    qw_i          = QW_W'(qw);
    word_len      = (mode == FILTER_3X3_DW) ? qw * TP_IN : qw;
    for (int i = 0; i < BUF_H; i++)
      for (int j = 0; j < BUF_W; j++)
        for (int c = 0; c < TP_IN; c++)
          act_i[i][j][c] = act_m[i][j][c];
  endtask

  // one beat with plane b of w_m, optionally after a few idle cycles
  task automatic drive_plane(input int b, input bit stall);
    int idle;
    idle = stall ? $urandom_range(3) : 0;
    for (int k = 0; k < idle; k++) begin
      @(posedge clk_i);
      #10;
      enable_i       = 1'b1;
      act_valid_i    = 1'b1;
      weight_valid_i = 1'b1;
      case ($urandom_range(2))
        0:       act_valid_i    = 1'b0;
        1:       weight_valid_i = 1'b0;
        default: enable_i       = 1'b0;
      endcase
    end
    @(posedge clk_i);
    #10;
    enable_i       = 1'b1;
    act_valid_i    = 1'b1;
    weight_valid_i = 1'b1;
    for (int r = 0; r < NR_ROWS; r++)
      for (int c = 0; c < TP_IN; c++)
        weight_i[r][c] = w_m[r][c][b];
  endtask

  // stop beating, then wait for the strobe and compare all PEs
  task automatic await_result();
    int n;
    @(posedge clk_i);
    #10;
    act_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!pres_valid_o && n < 4);
    assert (pres_valid_o)
      else begin
        errors++;
        $display("no result strobe after the last beat");
      end
    check_results();
  endtask

  task automatic clear_acc();
    @(posedge clk_i);
    #10;
    clear_i = 1'b1;
    @(posedge clk_i);
    #10;
    clear_i = 1'b0;
    for (int p = 0; p < NR_PE; p++) exp_acc[p] = '0;
    @(negedge clk_i);
    check_results(); // all zero after clear
  endtask

  // clear lands on beat n of a word, no strobe and nothing of the word survives
  task automatic abort_word(input filter_mode_e mode, input int qw, input int n);
    randomize_act();
    randomize_weights(qw);
    setup_word(mode, qw);
    for (int b = 0; b < n; b++) drive_plane(b % qw, 1'b0);
    clear_i = 1'b1; // same edge as beat n
    @(posedge clk_i);
    #10;
    clear_i        = 1'b0;
    act_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    for (int p = 0; p < NR_PE; p++) exp_acc[p] = '0;
    @(negedge clk_i);
    check_results();
  endtask

  task automatic run_dense(input int qw, input bit stall);
    randomize_act();
    randomize_weights(qw);
    for (int p = 0; p < NR_PE; p++) exp_acc[p] = exp_acc[p] + window_dot(p, -1);
    setup_word(FILTER_3X3, qw);
    for (int b = 0; b < qw; b++) drive_plane(b, stall);
    await_result();
  endtask

  // channel k uses only bit k of its planes, the other lanes carry junk
  task automatic run_depthwise(input int qw, input bit stall);
    randomize_act();
    setup_word(FILTER_3X3_DW, qw);
    for (int k = 0; k < TP_IN; k++) begin
      randomize_weights(qw);
      for (int p = 0; p < NR_PE; p++) exp_acc[p] = exp_acc[p] + window_dot(p, k);
      for (int b = 0; b < qw; b++) drive_plane(b, stall);
    end
    await_result();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h360d));
    errors         = 0;
    cycles         = 0;
    word_len       = 1;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    enable_i       = 1'b0;
    clear_i        = 1'b0;
    filter_mode_i  = FILTER_3X3;
    qw_i           = QW_W'(1);
    act_valid_i    = 1'b0;
    act_i          = '0;
    weight_valid_i = 1'b0;
    weight_i       = '0;
    for (int p = 0; p < NR_PE; p++) exp_acc[p] = '0;

    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (pres_valid_o == 1'b0)
      else begin
        errors++;
        $display("error pres_valid_o got %h exp %h after reset", pres_valid_o, 1'b0);
      end
    check_results();

    // single dense words
    for (int n = 0; n < 6; n++) begin
      clear_acc();
      run_dense($urandom_range(1, QW_MAX), 1'b0);
    end

    // two words add up, clear restarts from zero
    clear_acc();
    run_dense($urandom_range(1, QW_MAX), 1'b0);
    run_dense($urandom_range(1, QW_MAX), 1'b0);
    clear_acc();
    run_dense(QW_MAX, 1'b0);

    // clear on the last beat of a word, then in the middle of a sweep
    abort_word(FILTER_3X3, QW_MAX, QW_MAX);
    run_dense($urandom_range(1, QW_MAX), 1'b0);
    abort_word(FILTER_3X3_DW, 2, 3);
    run_depthwise(QW_MAX, 1'b0); // counters must restart at bit 0, channel 0

    // idle cycles between beats
    for (int n = 0; n < 4; n++) begin
      clear_acc();
      run_dense($urandom_range(1, QW_MAX), 1'b1);
    end

    // depthwise sweeps, last one with idle cycles
    for (int n = 0; n < 3; n++) begin
      clear_acc();
      run_depthwise($urandom_range(1, QW_MAX), n == 2);
    end

    repeat (2) @(posedge clk_i);
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/binconv_array.sv ====
/*
 * 2D array of bit-serial binary convolution PEs, 3x3 dense or depthwise
 * one weight bit-plane per beat, beat = enable & act_valid & weight_valid
 * no back-pressure, inputs must be held until their valid is seen
 * accumulators only clear on clear_i, which wins over a same-cycle beat
 */
`timescale 1ns/10ps

module binconv_array #(
  parameter int unsigned PE_H = binconv_pkg::PE_H, // PE rows
  parameter int unsigned PE_W = binconv_pkg::PE_W  // PE columns
) (
  // clock and reset
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // control
  input  logic                                  enable_i,
  input  logic                                  clear_i,
  input  binconv_pkg::filter_mode_e             filter_mode_i,
  input  logic [binconv_pkg::QW_W-1:0]          qw_i,           // 1..QW_MAX
  // activation buffer, pixel-major then channel
  input  logic                                  act_valid_i,
  input  logic [PE_H+1:0][PE_W+1:0]
               [binconv_pkg::TP_IN-1:0][binconv_pkg::ACT_W-1:0] act_i,
  // one weight bit-plane, per tap and channel
  input  logic                                  weight_valid_i,
  input  logic [binconv_pkg::NR_ROWS-1:0][binconv_pkg::TP_IN-1:0] weight_i,
  // partial results
  output logic [PE_H*PE_W-1:0][binconv_pkg::PRES_W-1:0] pres_o,
  output logic                                  pres_valid_o
);
  import binconv_pkg::*;

  localparam int unsigned NR_PE = PE_H * PE_W;

  //////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////

  // per-PE 3x3 windows of the buffer
  logic [NR_PE-1:0][NR_ROWS-1:0][TP_IN-1:0][ACT_W-1:0] win;

  binconv_ctrl_if #(
    .TP_IN ( TP_IN )
  ) ctrl_bus ();

  // sequencing shared by all PEs
  binconv_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .enable_i       ( enable_i       ),
    .clear_i        ( clear_i        ),
    .act_valid_i    ( act_valid_i    ),
    .weight_valid_i ( weight_valid_i ),
    .filter_mode_i  ( filter_mode_i  ),
    .qw_i           ( qw_i           ),
    .ctrl_o         ( ctrl_bus       ),
    .pres_valid_o   ( pres_valid_o   )
  );

  binconv_window_map #(
    .PE_H ( PE_H ),
    .PE_W ( PE_W )
  ) i_window_map (
    .act_i ( act_i ),
    .win_o ( win   )
  );

  //////////////////////////////////////////////////
  // PE grid
  //////////////////////////////////////////////////
  for (genvar p = 0; p < NR_PE; p++) begin : gen_pe
    // weight plane is broadcast, every PE applies the same filter
    binconv_pe #(
      .TP_IN ( TP_IN )
    ) i_pe (
      .clk_i    ( clk_i     ),
      .rst_ni   ( rst_ni    ),
      .ctrl_i   ( ctrl_bus  ),
      .win_i    ( win[p]    ),
      .weight_i ( weight_i  ),
      .pres_o   ( pres_o[p] )
    );
  end

endmodule

// ==== verilog/binconv_ctrl.sv ====
/*
 * bit-plane and depthwise channel sequencing for the PE array
 * dense result after qw_i beats, depthwise after qw_i * TP_IN beats
 * qw_i must stay stable while a result is being built
 */
`timescale 1ns/10ps

module binconv_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         enable_i,
  input  logic                         clear_i,
  input  logic                         act_valid_i,
  input  logic                         weight_valid_i,
  input  binconv_pkg::filter_mode_e    filter_mode_i,
  input  logic [binconv_pkg::QW_W-1:0] qw_i,
  binconv_ctrl_if.ctrl                 ctrl_o,
  output logic                         pres_valid_o
);
  import binconv_pkg::*;

  localparam int unsigned CH_W = $clog2(TP_IN);

  logic            beat;
  logic            dw_mode;
  logic            last_bit;
  logic            last_chan;
  logic            done;
  logic [QW_W-1:0] bit_cnt_q, bit_cnt_d;
  logic [CH_W-1:0] chan_cnt_q, chan_cnt_d;
  logic            pres_valid_q;

  assign beat      = enable_i & act_valid_i & weight_valid_i;
  assign dw_mode   = (filter_mode_i == FILTER_3X3_DW);
  assign last_bit  = (bit_cnt_q == qw_i - QW_W'(1));     // msb plane of the word
  assign last_chan = (chan_cnt_q == CH_W'(TP_IN - 1));

  // result complete on the msb plane, in depthwise only on the last channel
  assign done = beat & ~clear_i & last_bit & (~dw_mode | last_chan);

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////
  always_comb begin
    bit_cnt_d  = bit_cnt_q;
    chan_cnt_d = chan_cnt_q;
    if (clear_i) begin
      bit_cnt_d  = '0;
      chan_cnt_d = '0;
    end else if (beat) begin
      if (last_bit) begin
        bit_cnt_d = '0;
        // weight word finished, depthwise moves on to the next channel
        if (dw_mode) begin
          chan_cnt_d = last_chan ? '0 : chan_cnt_q + 1'b1;
        end
      end else begin
        bit_cnt_d = bit_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q    <= '0;
      chan_cnt_q   <= '0;
      pres_valid_q <= 1'b0;
    end else begin
      bit_cnt_q    <= bit_cnt_d;
      chan_cnt_q   <= chan_cnt_d;
      pres_valid_q <= done; // one cycle after the last beat
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////
  assign ctrl_o.beat    = beat;
  assign ctrl_o.bit_idx = bit_cnt_q;
  assign ctrl_o.clear   = clear_i;
  // one-hot lane in depthwise, all lanes in dense
  assign ctrl_o.chan_en = dw_mode ? (TP_IN'(1) << chan_cnt_q) : '1;

  assign pres_valid_o = pres_valid_q;

endmodule

// ==== verilog/binconv_ctrl_if.sv ====
/*
 * sequencing bus from the controller to every PE
 * all signals are combinational from the controller, sampled on the PE clock edge
 */
`timescale 1ns/10ps

interface binconv_ctrl_if #(
  parameter int unsigned TP_IN = binconv_pkg::TP_IN
);
  import binconv_pkg::*;

  logic             beat;    // one bit-plane consumed this edge
  logic [QW_W-1:0]  bit_idx; // current weight bit, lsb first
  logic [TP_IN-1:0] chan_en; // lane mask
  logic             clear;   // sync clear, beats beat

  // controller side
  modport ctrl (
    output beat, bit_idx, chan_en, clear
  );

  // PE side
  modport pe (
    input beat, bit_idx, chan_en, clear
  );

endinterface

// ==== verilog/binconv_pe.sv ====
/*
 * one output pixel, 9 taps x TP_IN lanes of binary products
 * each beat adds (tap sum << bit_idx) into a 32 bit unsigned accumulator
 * accumulator holds until clear, results of several words add up
 */
`timescale 1ns/10ps

module binconv_pe #(
  parameter int unsigned TP_IN = binconv_pkg::TP_IN
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  binconv_ctrl_if.pe                                              ctrl_i,
  input  logic [binconv_pkg::NR_ROWS-1:0][TP_IN-1:0][binconv_pkg::ACT_W-1:0] win_i,
  input  logic [binconv_pkg::NR_ROWS-1:0][TP_IN-1:0]             weight_i,
  output logic [binconv_pkg::PRES_W-1:0]                          pres_o
);
  import binconv_pkg::*;

  localparam int unsigned ROW_W   = ACT_W + $clog2(TP_IN);   // one tap
  localparam int unsigned TAP_W   = ROW_W + $clog2(NR_ROWS); // all taps
  localparam int unsigned SHIFT_W = TAP_W + QW_MAX - 1;      // after msb shift

  logic [NR_ROWS-1:0][ROW_W-1:0] row_sum;
  logic [TAP_W-1:0]              tap_sum;
  logic [SHIFT_W-1:0]            plane_sum;
  logic [PRES_W-1:0]             acc_q;

  //////////////////////////////////////////////////
  // taps
  //////////////////////////////////////////////////
  for (genvar r = 0; r < NR_ROWS; r++) begin : gen_row
    binconv_row #(
      .TP_IN ( TP_IN )
    ) i_row (
      .act_i     ( win_i[r]       ),
      .wbit_i    ( weight_i[r]    ),
      .chan_en_i ( ctrl_i.chan_en ),
      .sum_o     ( row_sum[r]     )
    );
  end

  // reduce the 9 tap sums
  always_comb begin
    tap_sum = '0;
    for (int r = 0; r < NR_ROWS; r++) begin
      tap_sum = tap_sum + TAP_W'(row_sum[r]);
    end
  end

  // weight the plane by its bit position
  assign plane_sum = SHIFT_W'(tap_sum) << ctrl_i.bit_idx;

  //////////////////////////////////////////////////
  // accumulator
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctrl_i.clear) begin
      acc_q <= '0;                              // clear wins over a beat
    end else if (ctrl_i.beat) begin
      acc_q <= acc_q + PRES_W'(plane_sum);
    end
  end

  assign pres_o = acc_q;

endmodule

// ==== verilog/binconv_pkg.sv ====
/*
 * sizes and types shared by the binary convolution array
 * grid values here are defaults, the top level may override PE_H and PE_W
 * activations and weights are unsigned, accumulator has no overflow flag
 */
package binconv_pkg;

  //////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////
  localparam int unsigned ACT_W   = 8;  // activation bits
  localparam int unsigned TP_IN   = 8;  // channels per pixel = lanes per row
  localparam int unsigned NR_ROWS = 9;  // one row per 3x3 tap

  // default PE grid and the buffer that feeds it
  localparam int unsigned PE_H  = 2;
  localparam int unsigned PE_W  = 2;
  localparam int unsigned NR_PE = PE_H * PE_W;
  localparam int unsigned BUF_H = PE_H + 2; // one pixel halo on each side
  localparam int unsigned BUF_W = PE_W + 2;

  // weight precision, qw field must hold QW_MAX itself
  localparam int unsigned QW_MAX = 8;
  localparam int unsigned QW_W   = 4;

  localparam int unsigned PRES_W = 32; // partial result width

  typedef enum logic {
    FILTER_3X3    = 1'b0, // dense, all channels per beat
    FILTER_3X3_DW = 1'b1  // depthwise, one channel per weight word
  } filter_mode_e;

endpackage

// ==== verilog/binconv_row.sv ====
/*
 * binary dot product of one filter tap over TP_IN channels
 * activation counts where weight bit and lane enable are both set
 * combinational, sum width covers TP_IN full-scale activations
 */
`timescale 1ns/10ps

module binconv_row #(
  parameter int unsigned TP_IN = binconv_pkg::TP_IN
) (
  input  logic [TP_IN-1:0][binconv_pkg::ACT_W-1:0]      act_i,
  input  logic [TP_IN-1:0]                              wbit_i,
  input  logic [TP_IN-1:0]                              chan_en_i,
  output logic [binconv_pkg::ACT_W+$clog2(TP_IN)-1:0]   sum_o
);
  import binconv_pkg::*;

  localparam int unsigned SUM_W = ACT_W + $clog2(TP_IN);

  logic [TP_IN-1:0] lane_on;

  // AND of weight bit and channel mask
  assign lane_on = wbit_i & chan_en_i;

  always_comb begin
    sum_o = '0;
    for (int c = 0; c < TP_IN; c++) begin
      if (lane_on[c]) begin
        sum_o = sum_o + SUM_W'(act_i[c]); // 1-bit weight times activation
      end
    end
  end

endmodule

// ==== verilog/binconv_window_map.sv ====
/*
 * routes each PE its 3x3 window of the activation buffer
 * buffer is (PE_H+2) x (PE_W+2) pixels, no padding or border handling
 * pure wiring by index, no logic levels
 */
`timescale 1ns/10ps

module binconv_window_map #(
  parameter int unsigned PE_H = binconv_pkg::PE_H,
  parameter int unsigned PE_W = binconv_pkg::PE_W
) (
  input  logic [PE_H+1:0][PE_W+1:0]
               [binconv_pkg::TP_IN-1:0][binconv_pkg::ACT_W-1:0] act_i,
  output logic [PE_H*PE_W-1:0][binconv_pkg::NR_ROWS-1:0]
               [binconv_pkg::TP_IN-1:0][binconv_pkg::ACT_W-1:0] win_o
);
  import binconv_pkg::*;

  localparam int unsigned NR_PE = PE_H * PE_W;
  localparam int unsigned FS    = 3; // filter side

  //////////////////////////////////////////////////
  // PE position plus tap offset
  //////////////////////////////////////////////////
  for (genvar p = 0; p < NR_PE; p++) begin : gen_pe
    localparam int unsigned PI = p / PE_W; // PE grid row
    localparam int unsigned PJ = p % PE_W; // PE grid column

    for (genvar r = 0; r < NR_ROWS; r++) begin : gen_tap
      localparam int unsigned FI = r / FS; // tap row
      localparam int unsigned FJ = r % FS; // tap column

      // whole pixel, lane c gets channel c
      assign win_o[p][r] = act_i[PI+FI][PJ+FJ];
    end
  end

endmodule
